// File: src/lsu_op_pkg.sv
//######################################
// LSU operation encodings
// Opcodes, classes and request kinds
//######################################

package lsu_op_pkg;

    // Load/store opcodes with loads in the low half
    typedef enum logic [3:0] {
        OP_LB   = 4'h0,
        OP_LH   = 4'h1,
        OP_LW   = 4'h2,
        OP_LBU  = 4'h4,
        OP_LHU  = 4'h5,
        OP_SB   = 4'h8,
        OP_SH   = 4'h9,
        OP_SW   = 4'ha,
        OP_FILL = 4'hf
    } op_e;

    typedef enum logic [1:0] {
        CLASS_LD   = 2'd0,
        CLASS_ST   = 2'd1,
        CLASS_FILL = 2'd2
    } op_class_e;

    // Source of the entry held in the stage register
    typedef enum logic [1:0] {
        KIND_ISSUE  = 2'd0,
        KIND_RETIRE = 2'd1,
        KIND_REPLAY = 2'd2,
        KIND_FILL   = 2'd3
    } req_kind_e;

    function automatic op_class_e op_class(input op_e op);
        case (op)
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: return CLASS_LD;
            OP_SB, OP_SH, OP_SW:                return CLASS_ST;
            default:                            return CLASS_FILL;
        endcase
    endfunction

endpackage

// File: src/lsu_bus_pkg.sv
//######################################
// LSU bus definitions
// Widths and structs between LSU blocks
//######################################

package lsu_bus_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int TAG_W  = 5;
    // Cache line width in bits
    localparam int LINE_W = 64;

    // Operation issued by the reservation station
    typedef struct packed {
        logic                valid;
        lsu_op_pkg::op_e     op;
        logic [TAG_W-1:0]    tag;
        logic [ADDR_W-1:0]   imm;
        logic [ADDR_W-1:0]   base;
        logic [DATA_W-1:0]   data;
    } issue_req_t;

    // Line fill from the miss queue
    typedef struct packed {
        logic                en;
        logic [ADDR_W-1:0]   addr;
        logic [LINE_W-1:0]   line;
        logic                dirty;
    } fill_req_t;

    // Store leaving the store queue
    typedef struct packed {
        logic                en;
        lsu_op_pkg::op_e     op;
        logic [TAG_W-1:0]    tag;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
    } retire_req_t;

    // Load coming back from the load queue
    typedef struct packed {
        logic                en;
        lsu_op_pkg::op_e     op;
        logic [TAG_W-1:0]    tag;
        logic [ADDR_W-1:0]   addr;
    } replay_req_t;

    typedef struct packed {
        logic                  valid;
        lsu_op_pkg::req_kind_e kind;
        lsu_op_pkg::op_e       op;
        logic [TAG_W-1:0]      tag;
        logic [ADDR_W-1:0]     addr;
        logic [DATA_W-1:0]     data;
    } cand_t;

    // Load or store queue allocation
    typedef struct packed {
        logic                lq_en;
        logic                sq_en;
        lsu_op_pkg::op_e     op;
        logic [TAG_W-1:0]    tag;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
    } alloc_t;

    // Registered entry handed to the next pipeline stage
    typedef struct packed {
        logic                  valid;
        lsu_op_pkg::req_kind_e kind;
        lsu_op_pkg::op_e       op;
        logic [TAG_W-1:0]      tag;
        logic [ADDR_W-1:0]     addr;
        logic [DATA_W-1:0]     data;
    } stage_t;

    typedef struct packed {
        logic                wr_en;
        logic                dirty;
        logic                fill;
        logic [LINE_W-1:0]   line;
    } dc_req_t;

endpackage

// File: src/lsu_issue_path.sv
//######################################
// LSU issue path
// Address generation and queue allocation
//######################################

module lsu_issue_path (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_flush,
    input  logic                    i_lq_full,
    input  logic                    i_sq_full,
    input  logic                    i_pending,
    input  lsu_bus_pkg::issue_req_t i_issue,
    output logic                    o_stall,
    output lsu_bus_pkg::cand_t      o_cand,
    output lsu_bus_pkg::alloc_t     o_alloc
);

    lsu_op_pkg::op_class_e          op_cls;
    logic                           is_ld;
    logic                           is_st;
    logic                           lq_blocked;
    logic                           sq_blocked;
    logic                           accept;
    logic [lsu_bus_pkg::ADDR_W-1:0] addr;

    logic                           alloc_lq_en_q;
    logic                           alloc_sq_en_q;
    lsu_op_pkg::op_e                alloc_op_q;
    logic [lsu_bus_pkg::TAG_W-1:0]  alloc_tag_q;
    logic [lsu_bus_pkg::ADDR_W-1:0] alloc_addr_q;
    logic [lsu_bus_pkg::DATA_W-1:0] alloc_data_q;

    assign op_cls = lsu_op_pkg::op_class(i_issue.op);
    assign is_ld  = (op_cls == lsu_op_pkg::CLASS_LD);
    assign is_st  = (op_cls == lsu_op_pkg::CLASS_ST);
    assign addr   = i_issue.base + i_issue.imm;

    // Full queue only matters for the matching class
    assign lq_blocked = i_lq_full & is_ld;
    assign sq_blocked = i_sq_full & is_st;

    // Internal requests always win over issue
    assign o_stall = lq_blocked | sq_blocked | i_pending;
    assign accept  = i_issue.valid & ~o_stall & ~i_flush;

    always_comb begin
        o_cand.valid = i_issue.valid & (is_ld | is_st) & ~lq_blocked & ~sq_blocked & ~i_flush;
        o_cand.kind  = lsu_op_pkg::KIND_ISSUE;
        o_cand.op    = i_issue.op;
        o_cand.tag   = i_issue.tag;
        o_cand.addr  = addr;
        o_cand.data  = i_issue.data;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            alloc_lq_en_q <= 1'b0;
            alloc_sq_en_q <= 1'b0;
        end else begin
            alloc_lq_en_q <= accept & is_ld;
            alloc_sq_en_q <= accept & is_st;
        end
    end

    always_ff @(posedge clk) begin
        alloc_op_q   <= i_issue.op;
        alloc_tag_q  <= i_issue.tag;
        alloc_addr_q <= addr;
        alloc_data_q <= i_issue.data;
    end

    always_comb begin
        o_alloc.lq_en = alloc_lq_en_q;
        o_alloc.sq_en = alloc_sq_en_q;
        o_alloc.op    = alloc_op_q;
        o_alloc.tag   = alloc_tag_q;
        o_alloc.addr  = alloc_addr_q;
        o_alloc.data  = alloc_data_q;
    end

endmodule

// File: src/lsu_internal_path.sv
//######################################
// LSU internal request path
// Picks fill, then retire, then replay
//######################################

module lsu_internal_path (
    input  logic                            i_flush,
    input  lsu_bus_pkg::fill_req_t          i_fill,
    input  lsu_bus_pkg::retire_req_t        i_retire,
    input  lsu_bus_pkg::replay_req_t        i_replay,
    output lsu_bus_pkg::cand_t              o_cand,
    output logic [lsu_bus_pkg::LINE_W-1:0]  o_line,
    output logic                            o_dirty,
    output logic                            o_pending,
    output logic                            o_sq_retire_stall,
    output logic                            o_lq_replay_stall
);

    assign o_pending = i_fill.en | i_retire.en | i_replay.en;

    // Retire waits on flush and fills, replay waits on anything above it
    assign o_sq_retire_stall = i_flush | i_fill.en;
    assign o_lq_replay_stall = i_retire.en | i_fill.en;

    // Fill data goes straight to the cache controls
    assign o_line  = i_fill.line;
    assign o_dirty = i_fill.dirty;

    always_comb begin
        o_cand.data = '0;
        if (i_fill.en) begin
            // A fill is never cancelled by flush
            o_cand.valid = 1'b1;
            o_cand.kind  = lsu_op_pkg::KIND_FILL;
            o_cand.op    = lsu_op_pkg::OP_FILL;
            o_cand.tag   = '0;
            o_cand.addr  = i_fill.addr;
        end else if (i_retire.en) begin
            o_cand.valid = ~i_flush;
            o_cand.kind  = lsu_op_pkg::KIND_RETIRE;
            o_cand.op    = i_retire.op;
            o_cand.tag   = i_retire.tag;
            o_cand.addr  = i_retire.addr;
            o_cand.data  = i_retire.data;
        end else if (i_replay.en) begin
            o_cand.valid = ~i_flush;
            o_cand.kind  = lsu_op_pkg::KIND_REPLAY;
            o_cand.op    = i_replay.op;
            o_cand.tag   = i_replay.tag;
            o_cand.addr  = i_replay.addr;
        end else begin
            // When idle the issue kind tells the mux to take the issue side
            o_cand.valid = 1'b0;
            o_cand.kind  = lsu_op_pkg::KIND_ISSUE;
            o_cand.op    = i_replay.op;
            o_cand.tag   = i_replay.tag;
            o_cand.addr  = i_replay.addr;
        end
    end

endmodule

// File: src/lsu_am_mux.sv
//######################################
// LSU stage mux
// Registers stage entry and cache controls
//######################################

module lsu_am_mux #(
    parameter int LQ_DEPTH = 8,
    parameter int SQ_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            i_arst_n,
    input  logic                            i_flush,
    input  lsu_bus_pkg::cand_t              i_int_cand,
    input  lsu_bus_pkg::cand_t              i_issue_cand,
    input  logic [lsu_bus_pkg::LINE_W-1:0]  i_line,
    input  logic                            i_dirty,
    input  logic [LQ_DEPTH-1:0]             i_lq_select,
    input  logic [SQ_DEPTH-1:0]             i_sq_select,
    output lsu_bus_pkg::stage_t             o_stage,
    output logic [LQ_DEPTH-1:0]             o_lq_select,
    output logic [SQ_DEPTH-1:0]             o_sq_select,
    output lsu_bus_pkg::dc_req_t            o_dc
);

    lsu_bus_pkg::cand_t             sel_cand;
    logic                           int_sel;
    logic                           fill_sel;
    logic                           retire_sel;

    logic                           stage_valid_q;
    lsu_op_pkg::req_kind_e          stage_kind_q;
    lsu_op_pkg::op_e                stage_op_q;
    logic [lsu_bus_pkg::TAG_W-1:0]  stage_tag_q;
    logic [lsu_bus_pkg::ADDR_W-1:0] stage_addr_q;
    logic [lsu_bus_pkg::DATA_W-1:0] stage_data_q;

    logic                           dc_wr_en_q;
    logic                           dc_fill_q;
    logic                           dc_dirty_q;
    logic [lsu_bus_pkg::LINE_W-1:0] dc_line_q;
    logic [LQ_DEPTH-1:0]            lq_select_q;
    logic [SQ_DEPTH-1:0]            sq_select_q;

    // Any internal request takes the stage even when it is flushed
    assign int_sel  = (i_int_cand.kind != lsu_op_pkg::KIND_ISSUE);
    assign sel_cand = int_sel ? i_int_cand : i_issue_cand;

    assign fill_sel   = (sel_cand.kind == lsu_op_pkg::KIND_FILL);
    assign retire_sel = (sel_cand.kind == lsu_op_pkg::KIND_RETIRE);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            stage_valid_q <= 1'b0;
            dc_wr_en_q    <= 1'b0;
            dc_fill_q     <= 1'b0;
        end else begin
            stage_valid_q <= sel_cand.valid;
            // Fills write regardless of flush, retires only without it
            dc_wr_en_q    <= fill_sel | (retire_sel & ~i_flush);
            dc_fill_q     <= fill_sel;
        end
    end

    always_ff @(posedge clk) begin
        stage_kind_q <= sel_cand.kind;
        stage_op_q   <= sel_cand.op;
        stage_tag_q  <= sel_cand.tag;
        stage_addr_q <= sel_cand.addr;
        stage_data_q <= sel_cand.data;
        dc_dirty_q   <= fill_sel ? i_dirty : retire_sel;
        dc_line_q    <= i_line;
        lq_select_q  <= i_lq_select;
        sq_select_q  <= i_sq_select;
    end

    always_comb begin
        o_stage.valid = stage_valid_q;
        o_stage.kind  = stage_kind_q;
        o_stage.op    = stage_op_q;
        o_stage.tag   = stage_tag_q;
        o_stage.addr  = stage_addr_q;
        o_stage.data  = stage_data_q;

        o_dc.wr_en    = dc_wr_en_q;
        o_dc.dirty    = dc_dirty_q;
        o_dc.fill     = dc_fill_q;
        o_dc.line     = dc_line_q;
    end

    assign o_lq_select = lq_select_q;
    assign o_sq_select = sq_select_q;

endmodule

// File: src/lsu_am_top.sv
//######################################
// LSU address generation and mux stage
//######################################

module lsu_am_top #(
    parameter int LQ_DEPTH = 8,
    parameter int SQ_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        i_arst_n,
    input  logic                        i_flush,
    input  logic                        i_lq_full,
    input  logic                        i_sq_full,
    input  lsu_bus_pkg::issue_req_t     i_issue,
    input  lsu_bus_pkg::fill_req_t      i_fill,
    input  lsu_bus_pkg::retire_req_t    i_retire,
    input  lsu_bus_pkg::replay_req_t    i_replay,
    input  logic [LQ_DEPTH-1:0]         i_lq_select,
    input  logic [SQ_DEPTH-1:0]         i_sq_select,
    output logic                        o_rs_stall,
    output logic                        o_sq_retire_stall,
    output logic                        o_lq_replay_stall,
    output lsu_bus_pkg::stage_t         o_stage,
    output lsu_bus_pkg::alloc_t         o_alloc,
    output lsu_bus_pkg::dc_req_t        o_dc,
    output logic [LQ_DEPTH-1:0]         o_lq_select,
    output logic [SQ_DEPTH-1:0]         o_sq_select
);

    lsu_bus_pkg::cand_t             int_cand;
    lsu_bus_pkg::cand_t             issue_cand;
    logic [lsu_bus_pkg::LINE_W-1:0] fill_line;
    logic                           fill_dirty;
    logic                           pending;

    lsu_internal_path u_internal (
        .i_flush           (i_flush),
        .i_fill            (i_fill),
        .i_retire          (i_retire),
        .i_replay          (i_replay),
        .o_cand            (int_cand),
        .o_line            (fill_line),
        .o_dirty           (fill_dirty),
        .o_pending         (pending),
        .o_sq_retire_stall (o_sq_retire_stall),
        .o_lq_replay_stall (o_lq_replay_stall)
    );

    // Issue side is held off while any internal request is pending
    lsu_issue_path u_issue (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_flush   (i_flush),
        .i_lq_full (i_lq_full),
        .i_sq_full (i_sq_full),
        .i_pending (pending),
        .i_issue   (i_issue),
        .o_stall   (o_rs_stall),
        .o_cand    (issue_cand),
        .o_alloc   (o_alloc)
    );

    lsu_am_mux #(
        .LQ_DEPTH (LQ_DEPTH),
        .SQ_DEPTH (SQ_DEPTH)
    ) u_mux (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_flush      (i_flush),
        .i_int_cand   (int_cand),
        .i_issue_cand (issue_cand),
        .i_line       (fill_line),
        .i_dirty      (fill_dirty),
        .i_lq_select  (i_lq_select),
        .i_sq_select  (i_sq_select),
        .o_stage      (o_stage),
        .o_lq_select  (o_lq_select),
        .o_sq_select  (o_sq_select),
        .o_dc         (o_dc)
    );

endmodule

// File: testbench/lsu_am_properties.sv
//######################################
// LSU stage properties
// Allocation and cache control rules
//######################################

module lsu_am_properties (
    input logic                 clk,
    input logic                 i_arst_n,
    input logic                 i_rs_stall,
    input lsu_bus_pkg::alloc_t  i_alloc,
    input lsu_bus_pkg::dc_req_t i_dc
);

    int failures = 0;

    // One operation never lands in both queues
    alloc_one_queue: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_alloc.lq_en && i_alloc.sq_en))
        else begin
            failures++;
            $error("load and store queue allocated in the same cycle");
        end

    fill_writes: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_dc.fill |-> i_dc.wr_en)
        else begin
            failures++;
            $error("cache fill without write enable");
        end

    // Stalled issue must not allocate
    stall_no_alloc: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_rs_stall |=> !(i_alloc.lq_en || i_alloc.sq_en))
        else begin
            failures++;
            $error("allocation after an issue stall");
        end

endmodule

bind lsu_am_top lsu_am_properties u_props (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_rs_stall (o_rs_stall),
    .i_alloc    (o_alloc),
    .i_dc       (o_dc)
);

// File: testbench/lsu_am_tests.svh
//######################################
// LSU stage directed tests
// Stimulus, reference model and checks
//######################################

// Request set applied by the next call to apply_and_check
lsu_bus_pkg::issue_req_t  nxt_issue;
lsu_bus_pkg::fill_req_t   nxt_fill;
lsu_bus_pkg::retire_req_t nxt_retire;
lsu_bus_pkg::replay_req_t nxt_replay;
logic                     nxt_flush;
logic                     nxt_lq_full;
logic                     nxt_sq_full;
logic [LQ_DEPTH-1:0]      nxt_lq_sel;
logic [SQ_DEPTH-1:0]      nxt_sq_sel;

task automatic check(input logic cond, input string what);
    checks++;
    assert (cond) else begin
        errors++;
        $display("CHECK FAILED at time %0t: %s", $time, what);
    end
endtask

task automatic report_test(input string name, input int start_errors);
    tests++;
    if (errors == start_errors) begin
        $display("Test %s: ok", name);
    end else begin
        $display("Test %s: %0d errors", name, errors - start_errors);
    end
endtask

function automatic logic [31:0] rand32();
    return $random(seed);
endfunction

function automatic lsu_op_pkg::op_e random_mem_op();
    logic [31:0] r;
    r = rand32();
    case (r[2:0])
        3'd0:    return lsu_op_pkg::OP_LB;
        3'd1:    return lsu_op_pkg::OP_LH;
        3'd2:    return lsu_op_pkg::OP_LW;
        3'd3:    return lsu_op_pkg::OP_LBU;
        3'd4:    return lsu_op_pkg::OP_LHU;
        3'd5:    return lsu_op_pkg::OP_SB;
        3'd6:    return lsu_op_pkg::OP_SH;
        default: return lsu_op_pkg::OP_SW;
    endcase
endfunction

// Load and store opcode groups
function automatic logic model_is_load(input lsu_op_pkg::op_e op);
    return op inside {lsu_op_pkg::OP_LB, lsu_op_pkg::OP_LH, lsu_op_pkg::OP_LW,
                      lsu_op_pkg::OP_LBU, lsu_op_pkg::OP_LHU};
endfunction

function automatic logic model_is_store(input lsu_op_pkg::op_e op);
    return op inside {lsu_op_pkg::OP_SB, lsu_op_pkg::OP_SH, lsu_op_pkg::OP_SW};
endfunction

function automatic logic outputs_idle();
    return !o_stage.valid && !o_alloc.lq_en && !o_alloc.sq_en && !o_dc.wr_en && !o_dc.fill;
endfunction

task automatic drive_idle();
    i_issue     <= '0;
    i_fill      <= '0;
    i_retire    <= '0;
    i_replay    <= '0;
    i_flush     <= 1'b0;
    i_lq_full   <= 1'b0;
    i_sq_full   <= 1'b0;
    i_lq_select <= '0;
    i_sq_select <= '0;
endtask

// Random operands for every source with enables chosen by the caller
task automatic build_requests(input logic issue_en, input logic fill_en,
                              input logic retire_en, input logic replay_en);
    logic [31:0] r;
    r = rand32();
    nxt_issue.valid = issue_en;
    nxt_issue.op    = random_mem_op();
    nxt_issue.tag   = r[lsu_bus_pkg::TAG_W-1:0];
    nxt_issue.imm   = rand32();
    nxt_issue.base  = rand32();
    nxt_issue.data  = rand32();
    nxt_fill.en     = fill_en;
    nxt_fill.addr   = rand32();
    nxt_fill.line   = {rand32(), rand32()};
    nxt_fill.dirty  = r[31];
    nxt_retire.en   = retire_en;
    nxt_retire.op   = lsu_op_pkg::OP_SW;
    nxt_retire.tag  = r[lsu_bus_pkg::TAG_W+7:8];
    nxt_retire.addr = rand32();
    nxt_retire.data = rand32();
    nxt_replay.en   = replay_en;
    nxt_replay.op   = lsu_op_pkg::OP_LW;
    nxt_replay.tag  = r[lsu_bus_pkg::TAG_W+15:16];
    nxt_replay.addr = rand32();
    nxt_flush       = 1'b0;
    nxt_lq_full     = 1'b0;
    nxt_sq_full     = 1'b0;
    nxt_lq_sel      = {{(LQ_DEPTH-1){1'b0}}, 1'b1} << (rand32() % LQ_DEPTH);
    nxt_sq_sel      = {{(SQ_DEPTH-1){1'b0}}, 1'b1} << (rand32() % SQ_DEPTH);
endtask

task automatic apply_and_check();
    logic                           pending;
    logic                           is_ld;
    logic                           is_st;
    logic                           stall;
    logic                           accept;
    logic [lsu_bus_pkg::ADDR_W-1:0] exp_addr;
    pending  = nxt_fill.en | nxt_retire.en | nxt_replay.en;
    is_ld    = model_is_load(nxt_issue.op);
    is_st    = model_is_store(nxt_issue.op);
    stall    = (is_ld & nxt_lq_full) | (is_st & nxt_sq_full) | pending;
    accept   = nxt_issue.valid & ~stall & ~nxt_flush;
    exp_addr = nxt_issue.base + nxt_issue.imm;

    @(posedge clk);
    i_issue     <= nxt_issue;
    i_fill      <= nxt_fill;
    i_retire    <= nxt_retire;
    i_replay    <= nxt_replay;
    i_flush     <= nxt_flush;
    i_lq_full   <= nxt_lq_full;
    i_sq_full   <= nxt_sq_full;
    i_lq_select <= nxt_lq_sel;
    i_sq_select <= nxt_sq_sel;
    @(negedge clk);
    check(o_rs_stall == stall, "issue stall");
    check(o_sq_retire_stall == (nxt_flush | nxt_fill.en), "retire stall");
    check(o_lq_replay_stall == (nxt_retire.en | nxt_fill.en), "replay stall");

    // Registered outputs show up one cycle after the inputs
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    check(o_alloc.lq_en == (accept & is_ld) && o_alloc.sq_en == (accept & is_st),
          "alloc enables");
    if (accept) begin
        check(o_alloc.op == nxt_issue.op && o_alloc.tag == nxt_issue.tag &&
              o_alloc.addr == exp_addr && o_alloc.data == nxt_issue.data, "alloc fields");
    end
    check(o_lq_select == nxt_lq_sel && o_sq_select == nxt_sq_sel, "select vectors");
    if (nxt_fill.en) begin
        check(o_stage.valid && o_stage.kind == lsu_op_pkg::KIND_FILL &&
              o_stage.op == lsu_op_pkg::OP_FILL && o_stage.tag == '0 &&
              o_stage.addr == nxt_fill.addr, "fill stage entry");
        check(o_dc.wr_en && o_dc.fill && o_dc.dirty == nxt_fill.dirty &&
              o_dc.line == nxt_fill.line, "fill cache controls");
    end else if (nxt_retire.en) begin
        check(o_stage.valid == !nxt_flush, "retire stage valid");
        if (!nxt_flush) begin
            check(o_stage.kind == lsu_op_pkg::KIND_RETIRE && o_stage.op == nxt_retire.op &&
                  o_stage.tag == nxt_retire.tag && o_stage.addr == nxt_retire.addr &&
                  o_stage.data == nxt_retire.data, "retire stage entry");
        end
        check(o_dc.wr_en == !nxt_flush && !o_dc.fill && o_dc.dirty, "retire cache controls");
    end else if (nxt_replay.en) begin
        check(o_stage.valid == !nxt_flush, "replay stage valid");
        if (!nxt_flush) begin
            check(o_stage.kind == lsu_op_pkg::KIND_REPLAY && o_stage.op == nxt_replay.op &&
                  o_stage.tag == nxt_replay.tag && o_stage.addr == nxt_replay.addr,
                  "replay stage entry");
        end
        check(!o_dc.wr_en && !o_dc.fill, "replay cache controls");
    end else begin
        check(o_stage.valid == accept, "issue stage valid");
        if (accept) begin
            check(o_stage.kind == lsu_op_pkg::KIND_ISSUE && o_stage.op == nxt_issue.op &&
                  o_stage.tag == nxt_issue.tag && o_stage.addr == exp_addr &&
                  o_stage.data == nxt_issue.data, "issue stage entry");
        end
        check(!o_dc.wr_en && !o_dc.fill, "issue cache controls");
    end
endtask

task automatic test_reset();
    int start_errors;
    start_errors = errors;
    repeat (RESET_CYCLES) begin
        @(posedge clk);
        @(negedge clk);
        check(outputs_idle(), "outputs low during reset");
    end
    @(posedge clk);
    i_arst_n <= 1'b1;
    repeat (2) begin
        @(negedge clk);
        check(outputs_idle(), "outputs low after reset");
    end
    report_test("reset", start_errors);
endtask

task automatic test_random_issue();
    int start_errors;
    start_errors = errors;
    repeat (NUM_RANDOM) begin
        build_requests(1'b1, 1'b0, 1'b0, 1'b0);
        apply_and_check();
    end
    report_test("random loads and stores", start_errors);
endtask

// Each class stalls on its own queue and passes on the other
task automatic test_backpressure();
    int start_errors;
    int c;
    start_errors = errors;
    for (c = 0; c < 4; c++) begin
        build_requests(1'b1, 1'b0, 1'b0, 1'b0);
        nxt_issue.op = (c == 0 || c == 3) ? lsu_op_pkg::OP_LW : lsu_op_pkg::OP_SW;
        nxt_lq_full  = (c < 2);
        nxt_sq_full  = (c >= 2);
        apply_and_check();
    end
    report_test("queue full back-pressure", start_errors);
endtask

// All internal sources first, then drop fill, retire and replay in turn
task automatic test_priority();
    int start_errors;
    int s;
    start_errors = errors;
    for (s = 0; s < 4; s++) begin
        build_requests(1'b1, s < 1, s < 2, s < 3);
        apply_and_check();
    end
    report_test("internal priority", start_errors);
endtask

task automatic test_flush();
    int start_errors;
    int c;
    start_errors = errors;
    for (c = 0; c < 4; c++) begin
        build_requests(1'b1, c == 3, c == 1, c == 2);
        nxt_flush = 1'b1;
        apply_and_check();
    end
    report_test("flush", start_errors);
endtask

// File: testbench/lsu_am_tb.sv
//######################################
// LSU stage testbench
// Directed tests with a cycle limit
//######################################

module lsu_am_tb;

    localparam int LQ_DEPTH     = 8;
    localparam int SQ_DEPTH     = 8;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_RANDOM   = 16;
    // Reset checks plus two cycles for each of the random and twelve directed requests
    localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + 2 + 2 * (NUM_RANDOM + 12));

    logic                     clk;
    logic                     i_arst_n;
    logic                     i_flush;
    logic                     i_lq_full;
    logic                     i_sq_full;
    lsu_bus_pkg::issue_req_t  i_issue;
    lsu_bus_pkg::fill_req_t   i_fill;
    lsu_bus_pkg::retire_req_t i_retire;
    lsu_bus_pkg::replay_req_t i_replay;
    logic [LQ_DEPTH-1:0]      i_lq_select;
    logic [SQ_DEPTH-1:0]      i_sq_select;
    logic                     o_rs_stall;
    logic                     o_sq_retire_stall;
    logic                     o_lq_replay_stall;
    lsu_bus_pkg::stage_t      o_stage;
    lsu_bus_pkg::alloc_t      o_alloc;
    lsu_bus_pkg::dc_req_t     o_dc;
    logic [LQ_DEPTH-1:0]      o_lq_select;
    logic [SQ_DEPTH-1:0]      o_sq_select;

    int seed   = 32'h5c02_a377;
    int errors = 0;
    int checks = 0;
    int tests  = 0;
    int cycles = 0;

    lsu_am_top #(
        .LQ_DEPTH (LQ_DEPTH),
        .SQ_DEPTH (SQ_DEPTH)
    ) dut (.*);

    `include "lsu_am_tests.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        drive_idle();
        i_arst_n <= 1'b0;
        test_reset();
        test_random_issue();
        test_backpressure();
        test_priority();
        test_flush();
        // Failures seen by the bound properties
        errors = errors + dut.u_props.failures;
        $display("Tests run %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+testbench
src/lsu_op_pkg.sv
src/lsu_bus_pkg.sv
src/lsu_issue_path.sv
src/lsu_internal_path.sv
src/lsu_am_mux.sv
src/lsu_am_top.sv
testbench/lsu_am_properties.sv
testbench/lsu_am_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = lsu_am_tb
FILELIST  = tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
